// ==== src/ub_pkg.sv ====
package ub_pkg;

    // buffer geometry
    localparam int UB_DEPTH  = 50;
    localparam int UB_DATA_W = 16;
    localparam int UB_ADDR_W = 6;

    // one stored word
    typedef logic [UB_DATA_W-1:0] ub_data_t;

    // cell address or pointer, wraps at 64
    typedef logic [UB_ADDR_W-1:0] ub_addr_t;

    // locations still to be read in a burst
    typedef logic [UB_ADDR_W-1:0] ub_count_t;

    // read sequencer states
    typedef enum logic [1:0] {
        READ_IDLE   = 2'b00,
        READ_ACTIVE = 2'b10
    } read_state_t;

    // what the lane registers load on the next edge
    typedef enum logic [1:0] {
        // drop both valids, keep data
        PHASE_NONE  = 2'b00,
        // single word on lane 1
        PHASE_FIRST = 2'b01,
        // two adjacent words
        PHASE_PAIR  = 2'b10,
        // single word on lane 2
        PHASE_LAST  = 2'b11
    } read_phase_t;

endpackage

// ==== src/ub_storage.sv ====
`timescale 1ns/100ps

module ub_storage (
    input  logic             clk,
    input  logic             rst,

    // write side, two adjacent cells starting at wr_addr
    input  ub_pkg::ub_addr_t wr_addr,
    input  logic             wr_en_lo,
    input  logic             wr_en_hi,
    input  ub_pkg::ub_data_t wr_data_lo,
    input  ub_pkg::ub_data_t wr_data_hi,

    // read side, two adjacent cells starting at rd_addr
    input  ub_pkg::ub_addr_t rd_addr,
    output ub_pkg::ub_data_t rd_word_lo,
    output ub_pkg::ub_data_t rd_word_hi
);

    ub_pkg::ub_data_t mem [ub_pkg::UB_DEPTH];

    ub_pkg::ub_addr_t wr_addr_hi;
    ub_pkg::ub_addr_t rd_addr_hi;

    // neighbour cells, wrapping at the pointer width
    assign wr_addr_hi = wr_addr + ub_pkg::ub_addr_t'(1);
    assign rd_addr_hi = rd_addr + ub_pkg::ub_addr_t'(1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ub_pkg::UB_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (wr_en_lo) begin
                mem[wr_addr] <= wr_data_lo;
            end
            if (wr_en_hi) begin
                mem[wr_addr_hi] <= wr_data_hi;
            end
        end
    end

    // asynchronous read, new data seen from the cycle after the write
    assign rd_word_lo = mem[rd_addr];
    assign rd_word_hi = mem[rd_addr_hi];

endmodule

// ==== src/ub_write_steer.sv ====
`timescale 1ns/100ps

module ub_write_steer (
    input  logic             clk,
    input  logic             rst,
    input  logic             write_start,
    input  logic             write_valid_1,
    input  logic             write_valid_2,
    input  ub_pkg::ub_data_t write_data_1,
    input  ub_pkg::ub_data_t write_data_2,

    output ub_pkg::ub_addr_t wr_addr,
    output logic             wr_en_lo,
    output logic             wr_en_hi,
    output ub_pkg::ub_data_t wr_data_lo,
    output ub_pkg::ub_data_t wr_data_hi
);

    ub_pkg::ub_addr_t wr_ptr;
    logic             both_valid;
    logic             any_valid;

    assign both_valid = write_valid_1 && write_valid_2;
    assign any_valid  = write_valid_1 || write_valid_2;

    assign wr_addr  = wr_ptr;
    assign wr_en_lo = write_start && any_valid;
    assign wr_en_hi = write_start && both_valid;

    // a pair puts lane 2 at the pointer and lane 1 above it;
    // a lone word always lands at the pointer
    always_comb begin
        if (both_valid || !write_valid_1) begin
            wr_data_lo = write_data_2;
        end else begin
            wr_data_lo = write_data_1;
        end
    end

    // only ever used as the upper cell of a pair
    assign wr_data_hi = write_data_1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (wr_en_hi) begin
            wr_ptr <= wr_ptr + ub_pkg::ub_addr_t'(2);
        end else if (wr_en_lo) begin
            wr_ptr <= wr_ptr + ub_pkg::ub_addr_t'(1);
        end
    end

endmodule

// ==== src/ub_read_sequencer.sv ====
`timescale 1ns/100ps

module ub_read_sequencer (
    input  logic                clk,
    input  logic                rst,
    input  logic                read_start,
    input  ub_pkg::ub_addr_t    read_addr,
    input  ub_pkg::ub_count_t   read_count,

    output ub_pkg::ub_addr_t    rd_addr,
    output ub_pkg::read_phase_t phase
);

    ub_pkg::read_state_t state;
    ub_pkg::read_state_t state_next;
    ub_pkg::ub_addr_t    rd_ptr;
    ub_pkg::ub_count_t   left;

    logic start_ok;
    logic more_pairs;
    logic last_one;

    // start only taken while idle
    assign start_ok   = (state == ub_pkg::READ_IDLE) && read_start;
    assign more_pairs = (state == ub_pkg::READ_ACTIVE) && (left > ub_pkg::ub_count_t'(1));
    assign last_one   = (state == ub_pkg::READ_ACTIVE) && (left == ub_pkg::ub_count_t'(1));

    always_comb begin
        case (state)
            ub_pkg::READ_IDLE: begin
                state_next = read_start ? ub_pkg::READ_ACTIVE : ub_pkg::READ_IDLE;
            end
            ub_pkg::READ_ACTIVE: begin
                state_next = more_pairs ? ub_pkg::READ_ACTIVE : ub_pkg::READ_IDLE;
            end
            default: begin
                state_next = ub_pkg::READ_IDLE;
            end
        endcase
    end

    // phase for the lane registers on the coming edge
    always_comb begin
        if (start_ok) begin
            phase = ub_pkg::PHASE_FIRST;
        end else if (more_pairs) begin
            phase = ub_pkg::PHASE_PAIR;
        end else if (last_one) begin
            phase = ub_pkg::PHASE_LAST;
        end else begin
            // count of 1 ends here with an empty cycle
            phase = ub_pkg::PHASE_NONE;
        end
    end

    // first word comes straight from the command address
    assign rd_addr = (state == ub_pkg::READ_IDLE) ? read_addr : rd_ptr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= ub_pkg::READ_IDLE;
            rd_ptr <= '0;
            left   <= '0;
        end else begin
            state <= state_next;
            if (start_ok) begin
                rd_ptr <= read_addr + ub_pkg::ub_addr_t'(1);
                left   <= read_count - ub_pkg::ub_count_t'(1);
            end else if (more_pairs) begin
                rd_ptr <= rd_ptr + ub_pkg::ub_addr_t'(2);
                left   <= left - ub_pkg::ub_count_t'(2);
            end else if (last_one) begin
                left   <= '0;
            end
        end
    end

endmodule

// ==== src/ub_read_lanes.sv ====
`timescale 1ns/100ps

module ub_read_lanes (
    input  logic                clk,
    input  logic                rst,
    input  logic                transpose,
    input  ub_pkg::read_phase_t phase,
    input  ub_pkg::ub_data_t    rd_word_lo,
    input  ub_pkg::ub_data_t    rd_word_hi,

    output ub_pkg::ub_data_t    data_1,
    output ub_pkg::ub_data_t    data_2,
    output logic                valid_1,
    output logic                valid_2
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            data_1  <= '0;
            data_2  <= '0;
            valid_1 <= 1'b0;
            valid_2 <= 1'b0;
        end else begin
            case (phase)
                ub_pkg::PHASE_FIRST: begin
                    // stagger starts on lane 1
                    data_1  <= rd_word_lo;
                    data_2  <= '0;
                    valid_1 <= 1'b1;
                    valid_2 <= 1'b0;
                end
                ub_pkg::PHASE_PAIR: begin
                    // transpose taken fresh on every pair
                    if (transpose) begin
                        data_1 <= rd_word_lo;
                        data_2 <= rd_word_hi;
                    end else begin
                        data_1 <= rd_word_hi;
                        data_2 <= rd_word_lo;
                    end
                    valid_1 <= 1'b1;
                    valid_2 <= 1'b1;
                end
                ub_pkg::PHASE_LAST: begin
                    // and ends on lane 2
                    data_1  <= '0;
                    data_2  <= rd_word_lo;
                    valid_1 <= 1'b0;
                    valid_2 <= 1'b1;
                end
                default: begin
                    valid_1 <= 1'b0;
                    valid_2 <= 1'b0;
                end
            endcase
        end
    end

endmodule

// ==== src/unified_buffer.sv ====
`timescale 1ns/100ps

module unified_buffer (
    input  logic              clk,
    input  logic              rst,

    // write side
    input  logic              write_start,
    input  logic              write_valid_1,
    input  logic              write_valid_2,
    input  ub_pkg::ub_data_t  write_data_1,
    input  ub_pkg::ub_data_t  write_data_2,

    // read command
    input  logic              read_start,
    input  ub_pkg::ub_addr_t  read_addr,
    input  ub_pkg::ub_count_t read_count,
    input  logic              transpose,

    // staggered read stream
    output ub_pkg::ub_data_t  data_1,
    output ub_pkg::ub_data_t  data_2,
    output logic              valid_1,
    output logic              valid_2
);

    ub_pkg::ub_addr_t    wr_addr;
    logic                wr_en_lo;
    logic                wr_en_hi;
    ub_pkg::ub_data_t    wr_data_lo;
    ub_pkg::ub_data_t    wr_data_hi;
    ub_pkg::ub_addr_t    rd_addr;
    ub_pkg::ub_data_t    rd_word_lo;
    ub_pkg::ub_data_t    rd_word_hi;
    ub_pkg::read_phase_t phase;

    ub_write_steer u_write_steer (
        .clk           (clk),
        .rst           (rst),
        .write_start   (write_start),
        .write_valid_1 (write_valid_1),
        .write_valid_2 (write_valid_2),
        .write_data_1  (write_data_1),
        .write_data_2  (write_data_2),
        .wr_addr       (wr_addr),
        .wr_en_lo      (wr_en_lo),
        .wr_en_hi      (wr_en_hi),
        .wr_data_lo    (wr_data_lo),
        .wr_data_hi    (wr_data_hi)
    );

    ub_storage u_storage (
        .clk        (clk),
        .rst        (rst),
        .wr_addr    (wr_addr),
        .wr_en_lo   (wr_en_lo),
        .wr_en_hi   (wr_en_hi),
        .wr_data_lo (wr_data_lo),
        .wr_data_hi (wr_data_hi),
        .rd_addr    (rd_addr),
        .rd_word_lo (rd_word_lo),
        .rd_word_hi (rd_word_hi)
    );

    ub_read_sequencer u_read_sequencer (
        .clk        (clk),
        .rst        (rst),
        .read_start (read_start),
        .read_addr  (read_addr),
        .read_count (read_count),
        .rd_addr    (rd_addr),
        .phase      (phase)
    );

    ub_read_lanes u_read_lanes (
        .clk        (clk),
        .rst        (rst),
        .transpose  (transpose),
        .phase      (phase),
        .rd_word_lo (rd_word_lo),
        .rd_word_hi (rd_word_hi),
        .data_1     (data_1),
        .data_2     (data_2),
        .valid_1    (valid_1),
        .valid_2    (valid_2)
    );

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic rst
);

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset over the first 3 rising edges
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== tests/ub_asserts.sv ====
`timescale 1ns/100ps

module ub_asserts (
    input logic clk,
    input logic rst,
    input logic read_start,
    input logic valid_1,
    input logic valid_2
);

    int assert_fails = 0;

    // outputs stay quiet while reset is applied
    quiet_in_reset: assert property (@(posedge clk) rst |-> (!valid_1 && !valid_2))
        else begin
            $error("valid output while reset is applied");
            assert_fails++;
        end

    // a stream only opens after a start command
    start_before_first: assert property (@(posedge clk) disable iff (rst)
        $rose(valid_1) |-> $past(read_start))
        else begin
            $error("valid_1 rose without read_start one cycle earlier");
            assert_fails++;
        end

    // lane 2 always trails lane 1 by at least one beat
    lane_2_trails: assert property (@(posedge clk) disable iff (rst)
        valid_2 |-> $past(valid_1))
        else begin
            $error("valid_2 high without valid_1 one cycle earlier");
            assert_fails++;
        end

endmodule

// ==== tests/tb_unified_buffer.sv ====
`timescale 1ns/100ps

module tb_unified_buffer;

    logic              clk;
    logic              rst;
    logic              write_start;
    logic              write_valid_1;
    logic              write_valid_2;
    ub_pkg::ub_data_t  write_data_1;
    ub_pkg::ub_data_t  write_data_2;
    logic              read_start;
    ub_pkg::ub_addr_t  read_addr;
    ub_pkg::ub_count_t read_count;
    logic              transpose;
    ub_pkg::ub_data_t  data_1;
    ub_pkg::ub_data_t  data_2;
    logic              valid_1;
    logic              valid_2;

    // reference memory and its write pointer
    ub_pkg::ub_data_t ref_mem [64];
    int               ref_wptr;

    // expected beats as {valid_1, valid_2, data_1, data_2}
    logic [33:0]      exp_q [$];
    logic [33:0]      exp_beat;
    string            test_name;
    int               errors;
    logic [31:0]      rng;

    tb_clock u_clock (.clk(clk), .rst(rst));

    unified_buffer DUT (.*);

    bind unified_buffer ub_asserts u_asserts (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // beat k of an even-count read with pair i ordered by bit i of tr
    function automatic logic [33:0] expected_beat(input int addr, input int count,
                                                  input logic [31:0] tr, input int k);
        int p;
        p = addr + 2 * k - 1;
        if (k == 0) begin
            return {2'b10, ref_mem[addr], 16'h0000};
        end else if (k == count / 2) begin
            return {2'b01, 16'h0000, ref_mem[addr + count - 1]};
        end else if (tr[k - 1]) begin
            return {2'b11, ref_mem[p], ref_mem[p + 1]};
        end
        return {2'b11, ref_mem[p + 1], ref_mem[p]};
    endfunction

    task automatic write_words(input logic v1, input logic v2,
                               input ub_pkg::ub_data_t d1, input ub_pkg::ub_data_t d2);
        @(posedge clk);
        write_start   <= 1'b1;
        write_valid_1 <= v1;
        write_valid_2 <= v2;
        write_data_1  <= d1;
        write_data_2  <= d2;
        // a pair puts lane 2 in the lower cell
        if (v1 && v2) begin
            ref_mem[ref_wptr]     = d2;
            ref_mem[ref_wptr + 1] = d1;
            ref_wptr += 2;
        end else if (v1 || v2) begin
            ref_mem[ref_wptr] = v1 ? d1 : d2;
            ref_wptr += 1;
        end
    endtask

    task automatic stop_writes();
        @(posedge clk);
        write_start   <= 1'b0;
        write_valid_1 <= 1'b0;
        write_valid_2 <= 1'b0;
    endtask

    task automatic run_read(input string name, input int addr, input int count,
                            input logic [31:0] tr, input int bursts);
        int beats;
        int hold;
        int j;
        int seen;
        int first_j;
        int last_j;
        beats = count / 2 + 1;
        // start stays high until the last burst has been taken
        hold = (bursts - 1) * beats + 1;
        test_name = name;
        for (int b = 0; b < bursts; b++) begin
            for (int k = 0; k < beats; k++) begin
                exp_q.push_back(expected_beat(addr, count, tr, k));
            end
        end
        @(posedge clk);
        read_start <= 1'b1;
        read_addr  <= ub_pkg::ub_addr_t'(addr);
        read_count <= ub_pkg::ub_count_t'(count);
        transpose  <= tr[0];
        j = 0;
        seen = 0;
        first_j = -1;
        last_j = -1;
        while (seen < bursts * beats) begin
            @(posedge clk);
            j++;
            if (j == hold) begin
                read_start <= 1'b0;
            end
            transpose <= tr[(j - 1) % beats];
            @(negedge clk);
            if (valid_1 || valid_2) begin
                seen++;
                if (first_j < 0) begin
                    first_j = j;
                end
                last_j = j;
            end
            if (j > 100) begin
                errors++;
                $display("timeout in %s, only %0d of %0d beats arrived", name, seen,
                         bursts * beats);
                break;
            end
        end
        if (first_j != 1 || last_j != bursts * beats) begin
            errors++;
            $display("FAILED %s: expected valid cycles 1..%0d, actual %0d..%0d", name,
                     bursts * beats, first_j, last_j);
        end
        @(posedge clk);
        read_start <= 1'b0;
        repeat (2) @(posedge clk);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%s ended with %0d expected beats never compared", name, exp_q.size());
            exp_q.delete();
        end
    endtask

    // compare every beat that carries a valid
    always @(negedge clk) begin
        if (!rst && (valid_1 || valid_2)) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected valid output during %s", test_name);
            end else begin
                exp_beat = exp_q.pop_front();
                if ({valid_1, valid_2, data_1, data_2} !== exp_beat) begin
                    errors++;
                    $display("FAILED %s: expected v=%b d1=%h d2=%h, actual v=%b d1=%h d2=%h",
                             test_name, exp_beat[33:32], exp_beat[31:16], exp_beat[15:0],
                             {valid_1, valid_2}, data_1, data_2);
                end
            end
        end
    end

    initial begin
        int  n;
        int  cnt;
        int  adr;
        logic room;
        write_start   = 1'b0;
        write_valid_1 = 1'b0;
        write_valid_2 = 1'b0;
        write_data_1  = '0;
        write_data_2  = '0;
        read_start    = 1'b0;
        read_addr     = '0;
        read_count    = '0;
        transpose     = 1'b0;
        rng = 32'he0fe_782a;
        errors = 0;
        ref_wptr = 0;
        for (int i = 0; i < 64; i++) begin
            ref_mem[i] = '0;
        end

        // outputs cleared during and right after reset
        test_name = "reset";
        n = 0;
        @(posedge clk);
        while (rst !== 1'b0) begin
            @(negedge clk);
            n++;
            if (valid_1 !== 1'b0 || valid_2 !== 1'b0 || data_1 !== '0 || data_2 !== '0) begin
                errors++;
                $display("FAILED reset: expected v=00 d1=0000 d2=0000, actual v=%b%b d1=%h d2=%h",
                         valid_1, valid_2, data_1, data_2);
            end
            if (n > 20) begin
                errors++;
                $display("timeout waiting for reset release");
                break;
            end
        end
        run_read("reset_read", 0, 4, 32'h0, 1);

        // pairs and single lanes over 10 cells
        write_words(1'b1, 1'b1, 16'h1111, 16'h2222);
        write_words(1'b1, 1'b1, 16'h3333, 16'h4444);
        write_words(1'b1, 1'b0, 16'h5555, 16'hdead);
        write_words(1'b0, 1'b1, 16'hbeef, 16'h6666);
        write_words(1'b1, 1'b1, 16'h7777, 16'h8888);
        write_words(1'b0, 1'b1, 16'hcafe, 16'h9999);
        write_words(1'b1, 1'b0, 16'haaaa, 16'hface);
        stop_writes();
        run_read("writes", 0, 10, 32'h0, 1);

        run_read("transpose_high", 0, 10, 32'hffff_ffff, 1);
        run_read("transpose_toggle", 0, 10, 32'h5555_5555, 1);

        // random writes kept inside the 50 cells
        for (int c = 0; c < 30; c++) begin
            rng = xorshift(rng);
            room = (ref_wptr + 2 <= ub_pkg::UB_DEPTH);
            write_words(rng[0] && room, rng[1] && room, rng[31:16], rng[15:0]);
        end
        stop_writes();
        for (int r = 0; r < 6; r++) begin
            rng = xorshift(rng);
            cnt = 2 * (1 + int'(rng[2:0]));
            if (cnt > ref_wptr) begin
                cnt = 2;
            end
            adr = int'(rng[15:8]) % (ref_wptr - cnt + 1);
            rng = xorshift(rng);
            run_read("random", adr, cnt, rng, 1);
        end

        run_read("back_to_back", 2, 6, 32'h0, 2);

        errors += DUT.u_asserts.assert_fails;
        $display("errors: %0d (assertion failures %0d)", errors, DUT.u_asserts.assert_fails);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== project.f ====
src/ub_pkg.sv
src/ub_storage.sv
src/ub_write_steer.sv
src/ub_read_sequencer.sv
src/ub_read_lanes.sv
src/unified_buffer.sv
tests/tb_clock.sv
tests/ub_asserts.sv
tests/tb_unified_buffer.sv
